// ==== rtl/uart_pkg.sv ====
/* Shared constants, widths and payload types for the two-channel UART hub.
   Modules import this package in their body and use scoped names in port lists */
package uart_pkg;

  // Clock cycles per UART bit must be even and at least 4
  localparam int CYCLES_PER_SYMBOL = 8;
  localparam int NUM_CHANNELS      = 2;
  localparam int LOG_DEPTH         = 16;

  typedef logic [7:0] uart_byte_t;
  typedef logic [0:0] chan_id_t;
  typedef logic [3:0] log_ptr_t;
  typedef logic [4:0] log_count_t;
  typedef logic [3:0] bit_cnt_t;
  typedef logic [7:0] cyc_cnt_t;

  // One received byte as reported by a receiver
  typedef struct packed {
    uart_byte_t data;
    logic       frame_err;
  } rx_event_t;

  // Tagged entry as stored in the receive log
  typedef struct packed {
    chan_id_t   channel;
    uart_byte_t data;
    logic       frame_err;
  } log_entry_t;

  typedef enum logic {TX_IDLE, TX_SEND} tx_state_t;

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

endpackage

// ==== rtl/uart_tx.sv ====
/* UART transmitter sending one 8N1 frame per accepted start strobe.
   Strobes that arrive while busy are ignored */
`timescale 1ns/1ps

module uart_tx (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 tx_start_i,
  input  uart_pkg::uart_byte_t tx_data_i,
  output logic                 tx_o,
  output logic                 tx_busy_o
);
  import uart_pkg::*;

  tx_state_t  state_q;
  logic [9:0] frame_q;
  cyc_cnt_t   cyc_q;
  bit_cnt_t   bit_q;
  logic       bit_end;
  logic       start_ok;

  assign bit_end  = (cyc_q == cyc_cnt_t'(CYCLES_PER_SYMBOL - 1));
  assign start_ok = (state_q == TX_IDLE) && tx_start_i;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= TX_IDLE;
      cyc_q   <= '0;
      bit_q   <= '0;
    end else begin
      case (state_q)
        TX_IDLE: begin
          if (tx_start_i) begin
            state_q <= TX_SEND;
            cyc_q   <= '0;
            bit_q   <= '0;
          end
        end
        TX_SEND: begin
          if (bit_end) begin
            cyc_q <= '0;
            // Stop bit is frame position 9
            if (bit_q == bit_cnt_t'(9)) begin
              state_q <= TX_IDLE;
            end else begin
              bit_q <= bit_q + bit_cnt_t'(1);
            end
          end else begin
            cyc_q <= cyc_q + cyc_cnt_t'(1);
          end
        end
        default: state_q <= TX_IDLE;
      endcase
    end
  end

  // Frame shifts out from bit 0 with the start bit first and the data LSB first
  always_ff @(posedge clk_i) begin
    if (start_ok) begin
      frame_q <= {1'b1, tx_data_i, 1'b0};
    end else if ((state_q == TX_SEND) && bit_end) begin
      frame_q <= {1'b1, frame_q[9:1]};
    end
  end

  assign tx_o      = (state_q == TX_SEND) ? frame_q[0] : 1'b1;
  assign tx_busy_o = (state_q == TX_SEND);

endmodule

// ==== rtl/uart_rx.sv ====
/* UART receiver for 8N1 frames with mid-bit sampling.
   False starts are dropped and each byte is reported with a stop-bit error flag */
`timescale 1ns/1ps

module uart_rx (
  input  logic                rst_ni,
  input  logic                clk_i,
  input  logic                rx_i,
  output logic                rx_valid_o,
  output uart_pkg::rx_event_t rx_event_o
);
  import uart_pkg::*;

  logic [1:0] sync_q;
  logic       rx_s;
  rx_state_t  state_q;
  cyc_cnt_t   cyc_q;
  bit_cnt_t   bit_q;
  uart_byte_t shift_q;
  logic       err_q;
  logic       valid_q;
  logic       half_end;
  logic       bit_end;

  assign rx_s     = sync_q[1];
  assign half_end = (cyc_q == cyc_cnt_t'(CYCLES_PER_SYMBOL / 2 - 1));
  assign bit_end  = (cyc_q == cyc_cnt_t'(CYCLES_PER_SYMBOL - 1));

  // Two-flop synchronizer that idles high so reset does not look like a start bit
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      sync_q <= 2'b11;
    end else begin
      sync_q <= {sync_q[0], rx_i};
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= RX_IDLE;
      cyc_q   <= '0;
      bit_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      cyc_q   <= cyc_q + cyc_cnt_t'(1);
      case (state_q)
        RX_IDLE: begin
          if (!rx_s) begin
            state_q <= RX_START;
            cyc_q   <= '0;
          end
        end
        RX_START: begin
          // Line back high at mid start bit means a glitch
          if (half_end) begin
            state_q <= rx_s ? RX_IDLE : RX_DATA;
            cyc_q   <= '0;
            bit_q   <= '0;
          end
        end
        RX_DATA: begin
          if (bit_end) begin
            cyc_q <= '0;
            if (bit_q == bit_cnt_t'(7)) begin
              state_q <= RX_STOP;
            end else begin
              bit_q <= bit_q + bit_cnt_t'(1);
            end
          end
        end
        RX_STOP: begin
          if (bit_end) begin
            state_q <= RX_IDLE;
            valid_q <= 1'b1;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // Data shifts in LSB first and the stop level is captured at its sample point
  always_ff @(posedge clk_i) begin
    if ((state_q == RX_DATA) && bit_end) begin
      shift_q <= {rx_s, shift_q[7:1]};
    end
    if ((state_q == RX_STOP) && bit_end) begin
      err_q <= !rx_s;
    end
  end

  assign rx_valid_o           = valid_q;
  assign rx_event_o.data      = shift_q;
  assign rx_event_o.frame_err = err_q;

endmodule

// ==== rtl/rx_log_arbiter.sv ====
/* Round-robin arbiter between the receivers for the single log write port.
   Each channel holds one pending event until it is granted */
`timescale 1ns/1ps

module rx_log_arbiter (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic [uart_pkg::NUM_CHANNELS-1:0]   rx_valid_i,
  input  uart_pkg::rx_event_t                 rx_event_i [uart_pkg::NUM_CHANNELS],
  output logic                                log_we_o,
  output uart_pkg::log_entry_t                log_entry_o
);
  import uart_pkg::*;

  logic [NUM_CHANNELS-1:0] pending_q;
  rx_event_t               event_q [NUM_CHANNELS];
  chan_id_t                last_q;
  logic                    grant_valid;
  chan_id_t                grant_id;
  logic                    log_we_q;
  log_entry_t              entry_q;

  // Search starts just after the channel granted last
  always_comb begin
    chan_id_t cand;
    grant_valid = 1'b0;
    grant_id    = last_q;
    for (int i = 1; i <= NUM_CHANNELS; i++) begin
      cand = chan_id_t'((int'(last_q) + i) % NUM_CHANNELS);
      if (!grant_valid && pending_q[cand]) begin
        grant_valid = 1'b1;
        grant_id    = cand;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      pending_q <= '0;
      last_q    <= '0;
      log_we_q  <= 1'b0;
    end else begin
      log_we_q <= grant_valid;
      if (grant_valid) begin
        last_q <= grant_id;
      end
      for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
        if (rx_valid_i[ch]) begin
          pending_q[ch] <= 1'b1;
        end else if (grant_valid && (grant_id == chan_id_t'(ch))) begin
          pending_q[ch] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
      if (rx_valid_i[ch]) begin
        event_q[ch] <= rx_event_i[ch];
      end
    end
    if (grant_valid) begin
      entry_q.channel   <= grant_id;
      entry_q.data      <= event_q[grant_id].data;
      entry_q.frame_err <= event_q[grant_id].frame_err;
    end
  end

  assign log_we_o    = log_we_q;
  assign log_entry_o = entry_q;

endmodule

// ==== rtl/rx_log_mem.sv ====
/* Receive log as a circular queue of tagged entries.
   The host reads the registered head and pops it; overflow stays set until reset */
`timescale 1ns/1ps

module rx_log_mem (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 log_we_i,
  input  uart_pkg::log_entry_t log_entry_i,
  input  logic                 log_pop_i,
  output logic                 log_valid_o,
  output uart_pkg::log_entry_t log_entry_o,
  output logic                 log_overflow_o
);
  import uart_pkg::*;

  log_entry_t mem_q [LOG_DEPTH];
  log_entry_t head_q;
  log_ptr_t   wr_ptr_q;
  log_ptr_t   rd_ptr_q;
  log_ptr_t   rd_ptr_d;
  log_count_t count_q;
  logic       overflow_q;
  logic       full;
  logic       push;
  logic       pop;

  assign full     = (count_q == log_count_t'(LOG_DEPTH));
  assign push     = log_we_i && !full;
  assign pop      = log_pop_i && (count_q != '0);
  assign rd_ptr_d = pop ? rd_ptr_q + log_ptr_t'(1) : rd_ptr_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_q <= 1'b0;
    end else begin
      rd_ptr_q <= rd_ptr_d;
      if (push) begin
        wr_ptr_q <= wr_ptr_q + log_ptr_t'(1);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + log_count_t'(1);
        2'b01:   count_q <= count_q - log_count_t'(1);
        default: count_q <= count_q;
      endcase
      if (log_we_i && full) begin
        overflow_q <= 1'b1;
      end
    end
  end

  // Head bypasses the array when the new entry lands at the next read slot
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= log_entry_i;
    end
    head_q <= (push && (wr_ptr_q == rd_ptr_d)) ? log_entry_i : mem_q[rd_ptr_d];
  end

  assign log_valid_o    = (count_q != '0);
  assign log_entry_o    = head_q;
  assign log_overflow_o = overflow_q;

endmodule

// ==== rtl/uart_hub_top.sv ====
/* Top of the two-channel UART hub.
   Per-channel transmitter and receiver, with both receivers logging into one queue */
`timescale 1ns/1ps

module uart_hub_top (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic [uart_pkg::NUM_CHANNELS-1:0] tx_start_i,
  input  uart_pkg::uart_byte_t              tx_data_i [uart_pkg::NUM_CHANNELS],
  output logic [uart_pkg::NUM_CHANNELS-1:0] tx_busy_o,
  output logic [uart_pkg::NUM_CHANNELS-1:0] tx_o,
  input  logic [uart_pkg::NUM_CHANNELS-1:0] rx_i,
  input  logic                              log_pop_i,
  output logic                              log_valid_o,
  output uart_pkg::log_entry_t              log_entry_o,
  output logic                              log_overflow_o
);
  import uart_pkg::*;

  logic [NUM_CHANNELS-1:0] rx_valid;
  rx_event_t               rx_event [NUM_CHANNELS];
  logic                    log_we;
  log_entry_t              log_wr_entry;

  for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_chan
    uart_tx u_tx (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .tx_start_i (tx_start_i[ch]),
      .tx_data_i  (tx_data_i[ch]),
      .tx_o       (tx_o[ch]),
      .tx_busy_o  (tx_busy_o[ch])
    );

    uart_rx u_rx (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .rx_i       (rx_i[ch]),
      .rx_valid_o (rx_valid[ch]),
      .rx_event_o (rx_event[ch])
    );
  end

  // Receivers share the log write port
  rx_log_arbiter u_arb (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rx_valid_i  (rx_valid),
    .rx_event_i  (rx_event),
    .log_we_o    (log_we),
    .log_entry_o (log_wr_entry)
  );

  rx_log_mem u_log (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .log_we_i       (log_we),
    .log_entry_i    (log_wr_entry),
    .log_pop_i      (log_pop_i),
    .log_valid_o    (log_valid_o),
    .log_entry_o    (log_entry_o),
    .log_overflow_o (log_overflow_o)
  );

endmodule

// ==== tests/tb_uart_hub.sv ====
/* Directed testbench for the two-channel UART hub.
   Drives loopback traffic and hand-made frames, then checks the receive log */
`timescale 1ns/1ps

module tb_uart_hub;
  import uart_pkg::*;

  localparam int CLK_NS      = 4;
  localparam int NUM_TESTS   = 6;
  localparam int FRAME_CYC   = 10 * CYCLES_PER_SYMBOL;
  localparam int WAIT_CYC    = FRAME_CYC + 4 * CYCLES_PER_SYMBOL;
  // The overflow test runs 17 back-to-back frames, so the margin is wide
  localparam int WATCHDOG_NS = NUM_TESTS * FRAME_CYC * CLK_NS * 40;

  logic                    clk = 1'b0;
  logic                    rst_n;
  logic [NUM_CHANNELS-1:0] tx_start;
  uart_byte_t              tx_data [NUM_CHANNELS];
  logic [NUM_CHANNELS-1:0] tx_busy;
  logic [NUM_CHANNELS-1:0] tx_line;
  logic [NUM_CHANNELS-1:0] rx_line;
  logic [NUM_CHANNELS-1:0] drv_line;
  logic [NUM_CHANNELS-1:0] line_sel;
  logic                    log_pop;
  logic                    log_valid;
  logic                    log_overflow;
  log_entry_t              log_entry;
  int                      seed;
  int                      errors;
  int                      tests_ok;
  int                      tests_bad;

  uart_hub_top uut (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .tx_start_i     (tx_start),
    .tx_data_i      (tx_data),
    .tx_busy_o      (tx_busy),
    .tx_o           (tx_line),
    .rx_i           (rx_line),
    .log_pop_i      (log_pop),
    .log_valid_o    (log_valid),
    .log_entry_o    (log_entry),
    .log_overflow_o (log_overflow)
  );

  always #(CLK_NS / 2) clk = ~clk;

  // Each receive line is its own transmitter or the bit-level driver
  always_comb begin
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      rx_line[c] = line_sel[c] ? drv_line[c] : tx_line[c];
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
    $display("Test failed");
    $finish;
  end

  function automatic log_entry_t make_entry(int ch, uart_byte_t data, logic err);
    log_entry_t e;
    e.channel   = chan_id_t'(ch);
    e.data      = data;
    e.frame_err = err;
    return e;
  endfunction

  task automatic check_entry(string name, log_entry_t exp, log_entry_t act);
    if (exp !== act) begin
      $display("** Error at %0t: %s expected ch %0d data %h err %b, got ch %0d data %h err %b",
               $time, name, exp.channel, exp.data, exp.frame_err,
               act.channel, act.data, act.frame_err);
      errors++;
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (exp !== act) begin
      $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic finish_test(string name, int err_before);
    if (errors == err_before) begin
      $display("%s: ok", name);
      tests_ok++;
    end else begin
      $display("%s: %0d errors", name, errors - err_before);
      tests_bad++;
    end
  endtask

  task automatic reset_dut();
    rst_n = 1'b0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic strobe_tx(int ch, uart_byte_t b);
    @(negedge clk);
    tx_start[ch] = 1'b1;
    tx_data[ch]  = b;
    @(negedge clk);
    tx_start[ch] = 1'b0;
  endtask

  task automatic send_byte(int ch, uart_byte_t b);
    int n;
    n = 0;
    while (tx_busy[ch] && (n < FRAME_CYC + 8)) begin
      @(negedge clk);
      n++;
    end
    if (tx_busy[ch]) begin
      $display("Transmitter of channel %0d stayed busy for %0d cycles", ch, n);
      errors++;
    end else begin
      strobe_tx(ch, b);
    end
  endtask

  // Start bit, eight data bits LSB first, then the chosen stop level
  task automatic drive_frame(int ch, uart_byte_t b, logic stop);
    @(negedge clk);
    drv_line[ch] = 1'b0;
    repeat (CYCLES_PER_SYMBOL) @(negedge clk);
    for (int i = 0; i < 8; i++) begin
      drv_line[ch] = b[i];
      repeat (CYCLES_PER_SYMBOL) @(negedge clk);
    end
    drv_line[ch] = stop;
    repeat (CYCLES_PER_SYMBOL) @(negedge clk);
    drv_line[ch] = 1'b1;
  endtask

  task automatic pop_entry(output log_entry_t e, output logic ok);
    int n;
    n  = 0;
    ok = 1'b0;
    e  = '0;
    while (!log_valid && (n < WAIT_CYC)) begin
      @(negedge clk);
      n++;
    end
    if (!log_valid) begin
      $display("No log entry appeared within %0d cycles at %0t", WAIT_CYC, $time);
      errors++;
    end else begin
      e       = log_entry;
      ok      = 1'b1;
      log_pop = 1'b1;
      @(negedge clk);
      log_pop = 1'b0;
    end
  endtask

  task automatic pop_and_check(string name, log_entry_t exp);
    log_entry_t act;
    logic       ok;
    pop_entry(act, ok);
    if (ok) begin
      check_entry(name, exp, act);
    end
  endtask

  task automatic expect_empty(int cycles);
    logic seen;
    seen = 1'b0;
    repeat (cycles) begin
      @(negedge clk);
      if (log_valid) seen = 1'b1;
    end
    check_bit("log_valid_o", 1'b0, seen);
  endtask

  task automatic loopback_test();
    int         err_before;
    uart_byte_t b;
    err_before = errors;
    for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
      b = uart_byte_t'($random(seed));
      send_byte(ch, b);
      pop_and_check("log_entry_o", make_entry(ch, b, 1'b0));
    end
    finish_test("loopback", err_before);
  endtask

  task automatic simultaneous_test();
    int         err_before;
    uart_byte_t b0;
    uart_byte_t b1;
    log_entry_t e0;
    log_entry_t e1;
    logic       ok0;
    logic       ok1;
    err_before = errors;
    b0 = uart_byte_t'($random(seed));
    b1 = uart_byte_t'($random(seed));
    @(negedge clk);
    tx_data[0] = b0;
    tx_data[1] = b1;
    tx_start   = '1;
    @(negedge clk);
    tx_start   = '0;
    pop_entry(e0, ok0);
    pop_entry(e1, ok1);
    // Arrival order is up to the arbiter
    if (ok0 && ok1) begin
      if (e0.channel == chan_id_t'(0)) begin
        check_entry("log_entry_o", make_entry(0, b0, 1'b0), e0);
        check_entry("log_entry_o", make_entry(1, b1, 1'b0), e1);
      end else begin
        check_entry("log_entry_o", make_entry(1, b1, 1'b0), e0);
        check_entry("log_entry_o", make_entry(0, b0, 1'b0), e1);
      end
    end
    finish_test("simultaneous", err_before);
  endtask

  task automatic stop_error_test();
    int         err_before;
    uart_byte_t b;
    err_before  = errors;
    b           = uart_byte_t'($random(seed));
    line_sel[1] = 1'b1;
    drive_frame(1, b, 1'b0);
    pop_and_check("log_entry_o", make_entry(1, b, 1'b1));
    line_sel[1] = 1'b0;
    finish_test("stop_error", err_before);
  endtask

  task automatic false_start_test();
    int err_before;
    err_before  = errors;
    line_sel[0] = 1'b1;
    @(negedge clk);
    drv_line[0] = 1'b0;
    repeat (CYCLES_PER_SYMBOL / 2 - 1) @(negedge clk);
    drv_line[0] = 1'b1;
    expect_empty(WAIT_CYC);
    line_sel[0] = 1'b0;
    finish_test("false_start", err_before);
  endtask

  task automatic overflow_test();
    int         err_before;
    int         n;
    uart_byte_t sent [LOG_DEPTH + 1];
    err_before = errors;
    for (int i = 0; i <= LOG_DEPTH; i++) begin
      sent[i] = uart_byte_t'($random(seed));
      send_byte(0, sent[i]);
    end
    n = 0;
    while (!log_overflow && (n < WAIT_CYC)) begin
      @(negedge clk);
      n++;
    end
    check_bit("log_overflow_o", 1'b1, log_overflow);
    for (int i = 0; i < LOG_DEPTH; i++) begin
      pop_and_check("log_entry_o", make_entry(0, sent[i], 1'b0));
    end
    check_bit("log_valid_o", 1'b0, log_valid);
    finish_test("overflow", err_before);
  endtask

  task automatic busy_strobe_test();
    int         err_before;
    uart_byte_t a;
    err_before = errors;
    a = uart_byte_t'($random(seed));
    send_byte(0, a);
    check_bit("tx_busy_o", 1'b1, tx_busy[0]);
    strobe_tx(0, ~a);
    pop_and_check("log_entry_o", make_entry(0, a, 1'b0));
    expect_empty(WAIT_CYC);
    finish_test("busy_strobe", err_before);
  endtask

  initial begin
    seed      = 32'hda7e;
    errors    = 0;
    tests_ok  = 0;
    tests_bad = 0;
    rst_n     = 1'b0;
    tx_start  = '0;
    drv_line  = '1;
    line_sel  = '0;
    log_pop   = 1'b0;
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      tx_data[c] = '0;
    end
    reset_dut();
    loopback_test();
    reset_dut();
    simultaneous_test();
    reset_dut();
    stop_error_test();
    reset_dut();
    false_start_test();
    reset_dut();
    overflow_test();
    reset_dut();
    busy_strobe_test();
    $display("Summary: %0d of %0d tests ok, %0d with errors", tests_ok, NUM_TESTS, tests_bad);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== files.f ====
rtl/uart_pkg.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/rx_log_arbiter.sv
rtl/rx_log_mem.sv
rtl/uart_hub_top.sv
tests/tb_uart_hub.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the UART hub testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module tb_uart_hub -f files.f \
  --Mdir obj_dir -o tb_uart_hub_sim

./obj_dir/tb_uart_hub_sim > sim.log
cat sim.log

if grep -q "Test passed" sim.log; then
  exit 0
fi
echo "Simulation reported errors, see sim.log"
exit 1
